// ==== source/quad_mac_pkg.sv ====
/*
 * quad MAC package: widths, element types and command structs
 * shared by the quad computation block
 */
package quad_mac_pkg;

	// four computation units, one byte lane each
	localparam int QUAD         = 4;
	localparam int NEURON_W     = 8;
	localparam int WEIGHT_W     = 8;
	localparam int CACHE_ADDR_W = 5;
	localparam int ITER_W       = 3;
	localparam int MAC_IDX_W    = 4;
	localparam int ACC_W        = 24;
	// two extra bits for the sum of four addends
	localparam int OUT_W        = ACC_W + 2;

	typedef logic [NEURON_W-1:0] neuron_t;
	typedef logic [WEIGHT_W-1:0] weight_t;
	typedef logic [ACC_W-1:0]    acc_t;
	typedef logic [OUT_W-1:0]    out_t;

	typedef struct packed {
		logic                    en;
		logic [CACHE_ADDR_W-1:0] addr;
	} cache_wr_t;

	typedef struct packed {
		logic                 en;
		logic [MAC_IDX_W-1:0] mac;
		logic [ITER_W-1:0]    iter;
	} weight_wr_t;

	// step is a one cycle pulse, clear zeroes the accumulators
	typedef struct packed {
		logic                    step;
		logic                    clear;
		logic [CACHE_ADDR_W-1:0] rd_addr;
		logic [ITER_W-1:0]       iteration;
	} mac_cmd_t;

endpackage

// ==== source/neuron_cache.sv ====
/*
 * neuron cache: 32-entry input neuron memory of one computation unit
 * with a registered read port
 */
`timescale 1ns/1ns

module neuron_cache
	import quad_mac_pkg::*;
(
	input  logic                    clk,
	input  cache_wr_t               wr_i,
	input  neuron_t                 wr_data_i,
	input  logic [CACHE_ADDR_W-1:0] rd_addr_i,
	input  logic                    rd_en_i,
	output neuron_t                 rd_data_o
);

	localparam int DEPTH = 2 ** CACHE_ADDR_W;

	neuron_t mem [DEPTH];

	// write port
	always_ff @(posedge clk) begin
		if (wr_i.en) begin
			mem[wr_i.addr] <= wr_data_i;
		end
	end

	// read data held while rd_en_i is low
	always_ff @(posedge clk) begin
		if (rd_en_i) begin
			rd_data_o <= mem[rd_addr_i];
		end
	end

endmodule

// ==== source/filter_pool.sv ====
/*
 * filter pool: one weight bank per MAC unit, indexed by iteration,
 * all banks read in parallel
 */
`timescale 1ns/1ns

module filter_pool
	import quad_mac_pkg::*;
#(
	parameter int NUM_MAC = 4
) (
	input  logic              clk,
	input  weight_wr_t        wr_i,
	input  weight_t           wr_data_i,
	input  logic [ITER_W-1:0] iteration_i,
	input  logic              rd_en_i,
	output weight_t           weights_o [NUM_MAC]
);

	localparam int BANK_DEPTH = 2 ** ITER_W;

	weight_t bank [NUM_MAC][BANK_DEPTH];

	// MAC index selects the bank, iteration the entry
	always_ff @(posedge clk) begin
		for (int m = 0; m < NUM_MAC; m++) begin
			if (wr_i.en && (wr_i.mac == MAC_IDX_W'(m))) begin
				bank[m][wr_i.iter] <= wr_data_i;
			end
		end
	end

	// one weight per MAC unit for the current iteration
	always_ff @(posedge clk) begin
		if (rd_en_i) begin
			for (int m = 0; m < NUM_MAC; m++) begin
				weights_o[m] <= bank[m][iteration_i];
			end
		end
	end

endmodule

// ==== source/computation_unit.sv ====
/*
 * computation unit: one byte lane of the quad, neuron cache and filter
 * pool feeding NUM_MAC multiply-accumulate units
 */
`timescale 1ns/1ns

module computation_unit
	import quad_mac_pkg::*;
#(
	parameter int NUM_MAC = 4
) (
	input  logic       clk,
	input  logic       rst_i,
	input  logic       subunit_en_i,
	input  neuron_t    data_i,
	input  cache_wr_t  cache_wr_i,
	input  weight_wr_t weight_wr_i,
	input  mac_cmd_t   cmd_i,
	output acc_t       acc_o [NUM_MAC]
);

	localparam int PROD_W = NEURON_W + WEIGHT_W;

	cache_wr_t  cache_wr;
	weight_wr_t weight_wr;
	logic       step;
	logic       step_q;
	neuron_t    neuron;
	weight_t    weights [NUM_MAC];
	logic [PROD_W-1:0] prod [NUM_MAC];

	// a disabled unit ignores writes and steps
	always_comb begin
		cache_wr     = cache_wr_i;
		cache_wr.en  = cache_wr_i.en & subunit_en_i;
		weight_wr    = weight_wr_i;
		weight_wr.en = weight_wr_i.en & subunit_en_i;
	end

	assign step = cmd_i.step & subunit_en_i;

	neuron_cache neuron_cache_inst (
		.clk       (clk),
		.wr_i      (cache_wr),
		.wr_data_i (data_i),
		.rd_addr_i (cmd_i.rd_addr),
		.rd_en_i   (step),
		.rd_data_o (neuron)
	);

	filter_pool #(
		.NUM_MAC (NUM_MAC)
	) filter_pool_inst (
		.clk         (clk),
		.wr_i        (weight_wr),
		.wr_data_i   (data_i),
		.iteration_i (cmd_i.iteration),
		.rd_en_i     (step),
		.weights_o   (weights)
	);

	// operands arrive one cycle after the step
	always_ff @(posedge clk) begin
		if (rst_i) begin
			step_q <= 1'b0;
		end else begin
			step_q <= step;
		end
	end

	always_comb begin
		for (int m = 0; m < NUM_MAC; m++) begin
			prod[m] = neuron * weights[m];
		end
	end

	// clear wins, caller keeps it apart from pending steps
	always_ff @(posedge clk) begin
		for (int m = 0; m < NUM_MAC; m++) begin
			if (rst_i || cmd_i.clear) begin
				acc_o[m] <= '0;
			end else if (step_q) begin
				acc_o[m] <= acc_o[m] + acc_t'(prod[m]);
			end
		end
	end

endmodule

// ==== source/quad_accumulator_adder.sv ====
/*
 * quad accumulator adder: sums the unit accumulators per MAC unit
 * following the subunit enable pattern, registered at stage finish
 */
`timescale 1ns/1ns

module quad_accumulator_adder
	import quad_mac_pkg::*;
#(
	parameter int NUM_MAC = 4
) (
	input  logic               clk,
	input  logic               rst_i,
	input  logic [QUAD-1:0]    quad_subunit_en_i,
	input  logic [NUM_MAC-1:0] mac_unit_en_i,
	input  logic               stage_finish_i,
	input  acc_t               unit_acc_i [QUAD][NUM_MAC],
	output out_t               accumulator_o [NUM_MAC],
	output logic               result_valid_o
);

	// flag is the index of the last unit summed
	logic [1:0] adders_flag;
	logic [1:0] mac_flag [NUM_MAC];
	out_t       quad_sum [NUM_MAC];

	always_comb begin
		case (quad_subunit_en_i)
			4'b0001: adders_flag = 2'd0;
			4'b0011: adders_flag = 2'd1;
			4'b0111: adders_flag = 2'd2;
			4'b1111: adders_flag = 2'd3;
			default: adders_flag = 2'd0;
		endcase
	end

	// masked MAC units fall back to unit 0 alone
	always_comb begin
		for (int m = 0; m < NUM_MAC; m++) begin
			mac_flag[m] = adders_flag & {2{mac_unit_en_i[m]}};
			quad_sum[m] = '0;
			for (int u = 0; u < QUAD; u++) begin
				if (2'(u) <= mac_flag[m]) begin
					quad_sum[m] = quad_sum[m] + out_t'(unit_acc_i[u][m]);
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			result_valid_o <= 1'b0;
			for (int m = 0; m < NUM_MAC; m++) begin
				accumulator_o[m] <= '0;
			end
		end else begin
			result_valid_o <= stage_finish_i;
			if (stage_finish_i) begin
				accumulator_o <= quad_sum;
			end
		end
	end

endmodule

// ==== source/quad_unit_cache_filter_mac.sv ====
/*
 * quad unit top: splits the data bus into byte lanes for four
 * computation units and joins their accumulators in the quad adder
 */
`timescale 1ns/1ns

module quad_unit_cache_filter_mac
	import quad_mac_pkg::*;
#(
	parameter int NUM_MAC = 4
) (
	input  logic                     clk,
	input  logic                     rst_i,
	input  logic [QUAD-1:0]          quad_subunit_en_i,
	input  logic [QUAD*NEURON_W-1:0] quad_data_bus_i,
	input  cache_wr_t                cache_wr_i,
	input  weight_wr_t               weight_wr_i,
	input  mac_cmd_t                 cmd_i,
	input  logic [NUM_MAC-1:0]       mac_unit_en_i,
	input  logic                     stage_finish_i,
	output out_t                     accumulator_o [NUM_MAC],
	output logic                     result_valid_o
);

	acc_t unit_acc [QUAD][NUM_MAC];

	// unit u owns byte lane u of the bus
	for (genvar u = 0; u < QUAD; u++) begin : g_unit
		computation_unit #(
			.NUM_MAC (NUM_MAC)
		) computation_unit_inst (
			.clk          (clk),
			.rst_i        (rst_i),
			.subunit_en_i (quad_subunit_en_i[u]),
			.data_i       (quad_data_bus_i[u*NEURON_W +: NEURON_W]),
			.cache_wr_i   (cache_wr_i),
			.weight_wr_i  (weight_wr_i),
			.cmd_i        (cmd_i),
			.acc_o        (unit_acc[u])
		);
	end

	quad_accumulator_adder #(
		.NUM_MAC (NUM_MAC)
	) quad_accumulator_adder_inst (
		.clk               (clk),
		.rst_i             (rst_i),
		.quad_subunit_en_i (quad_subunit_en_i),
		.mac_unit_en_i     (mac_unit_en_i),
		.stage_finish_i    (stage_finish_i),
		.unit_acc_i        (unit_acc),
		.accumulator_o     (accumulator_o),
		.result_valid_o    (result_valid_o)
	);

endmodule

// ==== verif/quad_unit_tests.svh ====
/*
 * directed tests for the quad unit, with a reference model that mirrors
 * the neuron caches, weight banks and unit accumulators
 */

neuron_t cache_mirror [QUAD][2**CACHE_ADDR_W];
weight_t weight_mirror [QUAD][NUM_MAC][2**ITER_W];
acc_t    acc_model [QUAD][NUM_MAC];
out_t    result_model [NUM_MAC];

// galois LFSR over x^32 + x^22 + x^2 + x + 1 stepping once per bit
function automatic logic [31:0] random_bits(input int width);
	logic [31:0] value;
	value = '0;
	for (int i = 0; i < width; i++) begin
		value[i] = lfsr_state[0];
		if (lfsr_state[0]) begin
			lfsr_state = (lfsr_state >> 1) ^ 32'h8020_0003;
		end else begin
			lfsr_state = lfsr_state >> 1;
		end
	end
	return value;
endfunction

// index of the last unit summed per the pattern table
function automatic int last_unit(input logic [QUAD-1:0] pattern, input logic mac_en);
	if (!mac_en) begin
		return 0;
	end
	case (pattern)
		4'b0011: return 1;
		4'b0111: return 2;
		4'b1111: return 3;
		default: return 0;
	endcase
endfunction

task automatic check_reset_state();
	for (int m = 0; m < NUM_MAC; m++) begin
		result_model[m] = '0;
	end
	repeat (5) begin
		@(negedge clk);
		assert (result_valid_o == 1'b0) else begin
			mismatch_count++;
			$display("mismatch result_valid_o: got %h expected %h", result_valid_o, 1'b0);
		end
		for (int m = 0; m < NUM_MAC; m++) begin
			assert (accumulator_o[m] == '0) else begin
				mismatch_count++;
				$display("mismatch accumulator_o[%0d]: got %h expected %h",
					m, accumulator_o[m], out_t'(0));
			end
		end
	end
endtask

// random bytes on every lane but only enabled units store them
task automatic load_operands(input logic [QUAD-1:0] pattern);
	logic [QUAD*NEURON_W-1:0] bus;
	for (int a = 0; a < 2**CACHE_ADDR_W; a++) begin
		bus = random_bits(QUAD * NEURON_W);
		@(posedge clk);
		quad_subunit_en_i <= pattern;
		quad_data_bus_i   <= bus;
		cache_wr_i.en     <= 1'b1;
		cache_wr_i.addr   <= CACHE_ADDR_W'(a);
		for (int u = 0; u < QUAD; u++) begin
			if (pattern[u]) begin
				cache_mirror[u][a] = bus[u*NEURON_W +: NEURON_W];
			end
		end
	end
	for (int m = 0; m < NUM_MAC; m++) begin
		for (int it = 0; it < 2**ITER_W; it++) begin
			bus = random_bits(QUAD * NEURON_W);
			@(posedge clk);
			cache_wr_i.en    <= 1'b0;
			quad_data_bus_i  <= bus;
			weight_wr_i.en   <= 1'b1;
			weight_wr_i.mac  <= MAC_IDX_W'(m);
			weight_wr_i.iter <= ITER_W'(it);
			for (int u = 0; u < QUAD; u++) begin
				if (pattern[u]) begin
					weight_mirror[u][m][it] = bus[u*WEIGHT_W +: WEIGHT_W];
				end
			end
		end
	end
	@(posedge clk);
	weight_wr_i.en <= 1'b0;
endtask

// clear and 8 back-to-back steps under pattern, then stage finish under
// finish_pattern and a compare of every MAC output
task automatic run_stage(
	input logic [QUAD-1:0]    pattern,
	input logic [NUM_MAC-1:0] mac_en,
	input logic [QUAD-1:0]    finish_pattern
);
	logic [CACHE_ADDR_W-1:0] addr;
	logic [ITER_W-1:0]       iter;
	out_t                    expected;
	logic                    got_valid;
	@(posedge clk);
	quad_subunit_en_i <= pattern;
	mac_unit_en_i     <= mac_en;
	cmd_i.clear       <= 1'b1;
	// clear is not gated, so every unit starts from zero
	for (int u = 0; u < QUAD; u++) begin
		for (int m = 0; m < NUM_MAC; m++) begin
			acc_model[u][m] = '0;
		end
	end
	for (int s = 0; s < 8; s++) begin
		addr = CACHE_ADDR_W'(random_bits(CACHE_ADDR_W));
		iter = ITER_W'(random_bits(ITER_W));
		@(posedge clk);
		cmd_i.clear     <= 1'b0;
		cmd_i.step      <= 1'b1;
		cmd_i.rd_addr   <= addr;
		cmd_i.iteration <= iter;
		for (int u = 0; u < QUAD; u++) begin
			for (int m = 0; m < NUM_MAC; m++) begin
				if (pattern[u]) begin
					acc_model[u][m] = acc_model[u][m] + acc_t'(cache_mirror[u][addr])
						* acc_t'(weight_mirror[u][m][iter]);
				end
			end
		end
	end
	@(posedge clk);
	cmd_i.step <= 1'b0;
	// last accumulation lands two edges after the last step
	@(posedge clk);
	@(negedge clk);
	// result register holds the previous stage until stage finish
	for (int m = 0; m < NUM_MAC; m++) begin
		assert (accumulator_o[m] == result_model[m]) else begin
			mismatch_count++;
			$display("mismatch accumulator_o[%0d]: got %h expected %h",
				m, accumulator_o[m], result_model[m]);
		end
	end
	@(posedge clk);
	quad_subunit_en_i <= finish_pattern;
	stage_finish_i    <= 1'b1;
	@(posedge clk);
	stage_finish_i <= 1'b0;
	got_valid = 1'b0;
	for (int c = 0; c < 8 && !got_valid; c++) begin
		@(negedge clk);
		got_valid = result_valid_o;
	end
	assert (got_valid) else begin
		missing_count++;
		$display("result_valid_o did not pulse after stage_finish_i (pattern %b)", pattern);
	end
	for (int m = 0; m < NUM_MAC; m++) begin
		expected = '0;
		for (int u = 0; u <= last_unit(finish_pattern, mac_en[m]); u++) begin
			expected = expected + out_t'(acc_model[u][m]);
		end
		result_model[m] = expected;
		if (got_valid) begin
			assert (accumulator_o[m] == expected) else begin
				mismatch_count++;
				$display("mismatch accumulator_o[%0d]: got %h expected %h",
					m, accumulator_o[m], expected);
			end
		end
	end
	if (got_valid) begin
		// the valid pulse lasts one cycle
		@(negedge clk);
		assert (result_valid_o == 1'b0) else begin
			mismatch_count++;
			$display("mismatch result_valid_o: got %h expected %h", result_valid_o, 1'b0);
		end
	end
endtask

task automatic test_full_quad();
	load_operands(4'b1111);
	run_stage(4'b1111, '1, 4'b1111);
endtask

task automatic test_partial_patterns();
	logic [QUAD-1:0] patterns [3];
	patterns = '{4'b0001, 4'b0011, 4'b0111};
	foreach (patterns[i]) begin
		load_operands(patterns[i]);
		run_stage(patterns[i], '1, patterns[i]);
	end
endtask

// units 1 and 3 keep older data for the full sums in later tests
task automatic test_sparse_pattern();
	load_operands(4'b0101);
	run_stage(4'b0101, '1, 4'b0101);
	// full pattern at finish shows what each unit accumulated
	run_stage(4'b0101, '1, 4'b1111);
endtask

task automatic test_mac_mask();
	logic [NUM_MAC-1:0] mask;
	for (int m = 0; m < NUM_MAC; m++) begin
		mask[m] = m[0];
	end
	run_stage(4'b1111, mask, 4'b1111);
	run_stage(4'b0011, ~mask, 4'b0011);
endtask

task automatic test_clear_between_stages();
	load_operands(4'b1111);
	run_stage(4'b1111, '1, 4'b1111);
	run_stage(4'b1111, '1, 4'b1111);
endtask

// ==== verif/quad_unit_tb.sv ====
/*
 * quad unit testbench: clock, reset, DUT, LFSR stimulus source,
 * error counters, timeout and closing line
 */
`timescale 1ns/1ns

module quad_unit_tb
	import quad_mac_pkg::*;
();

	localparam int NUM_MAC     = 4;
	// about 600 cycles of tests, with margin
	localparam int CYCLE_LIMIT = 4000;

	logic                     clk;
	logic                     rst_i;
	logic [QUAD-1:0]          quad_subunit_en_i;
	logic [QUAD*NEURON_W-1:0] quad_data_bus_i;
	cache_wr_t                cache_wr_i;
	weight_wr_t               weight_wr_i;
	mac_cmd_t                 cmd_i;
	logic [NUM_MAC-1:0]       mac_unit_en_i;
	logic                     stage_finish_i;
	out_t                     accumulator_o [NUM_MAC];
	logic                     result_valid_o;

	logic [31:0] lfsr_state;
	int          mismatch_count;
	int          missing_count;
	int          cycle_count = 0;

	quad_unit_cache_filter_mac #(
		.NUM_MAC (NUM_MAC)
	) quad_unit_cache_filter_mac_inst (
		.clk               (clk),
		.rst_i             (rst_i),
		.quad_subunit_en_i (quad_subunit_en_i),
		.quad_data_bus_i   (quad_data_bus_i),
		.cache_wr_i        (cache_wr_i),
		.weight_wr_i       (weight_wr_i),
		.cmd_i             (cmd_i),
		.mac_unit_en_i     (mac_unit_en_i),
		.stage_finish_i    (stage_finish_i),
		.accumulator_o     (accumulator_o),
		.result_valid_o    (result_valid_o)
	);

	// 20 ns period
	always #10 clk = ~clk;

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count == CYCLE_LIMIT) begin
			$display("timeout: run still going after %0d cycles", CYCLE_LIMIT);
			$display("errors: %0d mismatches, %0d missing results",
				mismatch_count, missing_count);
			$display("sim failed");
			$finish;
		end
	end

	`include "quad_unit_tests.svh"

	initial begin
		clk               = 1'b0;
		rst_i             = 1'b1;
		quad_subunit_en_i = '0;
		quad_data_bus_i   = '0;
		cache_wr_i        = '0;
		weight_wr_i       = '0;
		cmd_i             = '0;
		mac_unit_en_i     = '0;
		stage_finish_i    = 1'b0;
		lfsr_state        = 32'h41f0_84c4;
		mismatch_count    = 0;
		missing_count     = 0;
		repeat (10) @(posedge clk);
		rst_i <= 1'b0;

		check_reset_state();
		test_full_quad();
		test_partial_patterns();
		test_sparse_pattern();
		test_mac_mask();
		test_clear_between_stages();

		$display("errors: %0d mismatches, %0d missing results",
			mismatch_count, missing_count);
		if (mismatch_count + missing_count == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

// ==== vlog.f ====
+incdir+verif
source/quad_mac_pkg.sv
source/neuron_cache.sv
source/filter_pool.sv
source/computation_unit.sv
source/quad_accumulator_adder.sv
source/quad_unit_cache_filter_mac.sv
verif/quad_unit_tb.sv

// ==== Bender.yml ====
package:
  name: quad_unit_cache_filter_mac

sources:
  # RTL in compile order
  - files:
      - source/quad_mac_pkg.sv
      - source/neuron_cache.sv
      - source/filter_pool.sv
      - source/computation_unit.sv
      - source/quad_accumulator_adder.sv
      - source/quad_unit_cache_filter_mac.sv
  # testbench
  - target: test
    include_dirs:
      - verif
    files:
      - verif/quad_unit_tb.sv
